//--- hdl/ldst_pkg.sv
// Shared widths, op codes and the age compare of the load/store block.
// Addresses count words. There is no byte addressing and no alignment check.
// Issue numbers wrap at 64, so is_older only holds while fewer than 64 are live.
`default_nettype none

package ldst_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Widths with a meaning
	////////////////////////////////////////////////////////////////////////////

	typedef logic [31:0] addr_t;		// Word address
	typedef logic [31:0] data_t;		// One vector element
	typedef logic [7:0]  len_t;			// Elements per command, 0 allowed
	typedef logic [7:0]  idx_t;			// Element index inside a command
	typedef logic [5:0]  issue_no_t;	// Wrapping issue number
	typedef logic [4:0]  dst_t;			// Destination vector register
	typedef logic [1:0]  op_type_t;

	////////////////////////////////////////////////////////////////////////////
	// Op codes
	////////////////////////////////////////////////////////////////////////////

	// Memory command; op_class then selects load (0) or store (1)
	localparam op_type_t OP_MEM = 2'b11;

	////////////////////////////////////////////////////////////////////////////
	// Age compare
	////////////////////////////////////////////////////////////////////////////

	// True when a was issued before b. Age is the distance back from newest,
	// so the compare stays right across the wrap of the issue counter
	function automatic logic is_older(
		input issue_no_t a,
		input issue_no_t b,
		input issue_no_t newest
	);
		issue_no_t age_a;
		issue_no_t age_b;
		age_a = newest - a;		// Lifetime of a
		age_b = newest - b;		// Lifetime of b
		return age_a > age_b;
	endfunction

endpackage

`default_nettype wire

//--- hdl/ldst_cmd_decode.sv
// Splits issued commands into load and store pushes, one cycle after acceptance.
// Stall is combinational from the target queue's full flag; others never stall.
// Non-memory commands are taken and dropped.
`default_nettype none

module ldst_cmd_decode (
	input  wire                  clock,
	input  wire                  rst_n,
	input  wire                  req,
	input  wire ldst_pkg::op_type_t  op_type,
	input  wire                  op_class,
	input  wire ldst_pkg::dst_t      dst,
	input  wire ldst_pkg::issue_no_t issue_no,
	input  wire ldst_pkg::len_t      src_len,
	input  wire ldst_pkg::addr_t     src_stride,
	input  wire ldst_pkg::addr_t     src_base,
	input  wire                  ld_full,
	input  wire                  st_full,
	output logic                 issue_stall,
	output logic                 ld_push,
	output logic                 st_push,
	output ldst_pkg::len_t       cmd_len,
	output ldst_pkg::addr_t      cmd_stride,
	output ldst_pkg::addr_t      cmd_base,
	output ldst_pkg::dst_t       cmd_dst,
	output ldst_pkg::issue_no_t  cmd_no,
	output ldst_pkg::issue_no_t  newest_no
);
	import ldst_pkg::*;

	logic is_mem;
	logic is_ld;
	logic is_st;
	logic accept;

	assign is_mem      = (op_type == OP_MEM);
	assign is_ld       = is_mem & ~op_class;
	assign is_st       = is_mem & op_class;
	assign issue_stall = req & ((is_ld & ld_full) | (is_st & st_full));
	assign accept      = req & ~issue_stall;		// Taken on this edge

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			ld_push   <= 1'b0;
			st_push   <= 1'b0;
			newest_no <= '0;
		end else begin
			ld_push <= accept & is_ld;			// One-cycle pulse
			st_push <= accept & is_st;
			if (accept & is_mem) begin
				newest_no <= issue_no;			// Reference point for ages
			end
		end
	end

	// Descriptor shared by both directions; only the push tells them apart
	always_ff @(posedge clock) begin
		if (accept & is_mem) begin
			cmd_len    <= src_len;
			cmd_stride <= src_stride;
			cmd_base   <= src_base;
			cmd_dst    <= dst;
			cmd_no     <= issue_no;
		end
	end

endmodule

`default_nettype wire

//--- hdl/ldst_channel.sv
// One direction: descriptor queue and strided walker over base + i * stride.
// The head entry stays queued until its done; full counts the push in flight.
// Loads expect rvalid exactly one cycle after the grant.
// Two dones of one channel are always at least one cycle apart.
`default_nettype none

module ldst_channel #(
	parameter int DEPTH_CMD = 4,
	parameter bit IS_STORE  = 1'b0
)(
	input  wire                      clock,
	input  wire                      rst_n,
	input  wire                      push,
	input  wire ldst_pkg::len_t      cmd_len,
	input  wire ldst_pkg::addr_t     cmd_stride,
	input  wire ldst_pkg::addr_t     cmd_base,
	input  wire ldst_pkg::dst_t      cmd_dst,
	input  wire ldst_pkg::issue_no_t cmd_no,
	input  wire                      gnt,
	input  wire                      rvalid,
	input  wire ldst_pkg::data_t     st_wdata,
	input  wire                      st_wvalid,
	output logic                     full,
	output logic                     mem_req,
	output ldst_pkg::addr_t          mem_addr,
	output ldst_pkg::data_t          mem_wdata,
	output logic                     st_wready,
	output ldst_pkg::idx_t           cur_idx,
	output ldst_pkg::dst_t           cur_dst,
	output logic                     done,
	output ldst_pkg::dst_t           done_dst,
	output ldst_pkg::issue_no_t      done_no
);
	import ldst_pkg::*;

	localparam int ptr_w = $clog2(DEPTH_CMD);
	localparam int cnt_w = $clog2(DEPTH_CMD + 1);

	typedef enum logic [1:0] {IDLE, RUN, DRAIN} state_t;

	len_t             q_len    [DEPTH_CMD];
	addr_t            q_stride [DEPTH_CMD];
	addr_t            q_base   [DEPTH_CMD];
	dst_t             q_dst    [DEPTH_CMD];
	issue_no_t        q_no     [DEPTH_CMD];
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic [cnt_w-1:0] cnt;
	logic             q_empty;
	len_t             hd_len;
	addr_t            hd_stride;
	addr_t            hd_base;
	dst_t             hd_dst;
	issue_no_t        hd_no;
	state_t           state;
	idx_t             idx;
	addr_t            addr;
	data_t            wdata_q;
	logic             have_data;
	logic             last_el;
	logic             fin;

	////////////////////////////////////////////////////////////////////////////
	// Descriptor queue
	////////////////////////////////////////////////////////////////////////////

	// Empty queue bypass so a push starts the walker on the same edge
	assign q_empty   = (cnt == '0);
	assign hd_len    = q_empty ? cmd_len    : q_len[rd_ptr];
	assign hd_stride = q_empty ? cmd_stride : q_stride[rd_ptr];
	assign hd_base   = q_empty ? cmd_base   : q_base[rd_ptr];
	assign hd_dst    = q_empty ? cmd_dst    : q_dst[rd_ptr];
	assign hd_no     = q_empty ? cmd_no     : q_no[rd_ptr];

	assign full = (cnt == cnt_w'(DEPTH_CMD)) | (push & (cnt == cnt_w'(DEPTH_CMD - 1)));

	always_ff @(posedge clock) begin
		if (push) begin
			q_len[wr_ptr]    <= cmd_len;
			q_stride[wr_ptr] <= cmd_stride;
			q_base[wr_ptr]   <= cmd_base;
			q_dst[wr_ptr]    <= cmd_dst;
			q_no[wr_ptr]     <= cmd_no;
		end
	end

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			cnt    <= '0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == ptr_w'(DEPTH_CMD - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (fin) begin							// Pop at completion
				rd_ptr <= (rd_ptr == ptr_w'(DEPTH_CMD - 1)) ? '0 : rd_ptr + 1'b1;
			end
			cnt <= cnt + cnt_w'(push) - cnt_w'(fin);
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Walker
	////////////////////////////////////////////////////////////////////////////

	assign last_el   = (idx_t'(idx + 1'b1) == hd_len);
	assign mem_req   = (state == RUN) & (have_data | ~IS_STORE);
	assign mem_addr  = addr;
	assign mem_wdata = wdata_q;
	assign st_wready = IS_STORE & (state == RUN) & ~have_data;
	assign cur_idx   = idx_t'(idx - 1'b1);		// Element granted last edge
	assign cur_dst   = hd_dst;

	always_comb begin
		case (state)
			IDLE:    fin = (push | ~q_empty) & (hd_len == '0) & ~done;	// Zero count
			RUN:     fin = IS_STORE & gnt & last_el;
			DRAIN:   fin = rvalid;						// Last read back
			default: fin = 1'b0;
		endcase
	end

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			state     <= IDLE;
			have_data <= 1'b0;
			done      <= 1'b0;
		end else begin
			done <= fin;
			if (st_wready & st_wvalid) begin
				have_data <= 1'b1;
			end else if (gnt) begin
				have_data <= 1'b0;				// Word gone to memory
			end
			case (state)
				IDLE: begin
					if ((push | ~q_empty) & (hd_len != '0)) begin
						state <= RUN;
					end
				end
				RUN: begin
					if (gnt & last_el) begin
						state <= IS_STORE ? IDLE : DRAIN;
					end
				end
				DRAIN: begin
					if (rvalid) begin
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (state == IDLE) begin
			idx  <= '0;
			addr <= hd_base;
		end else if (gnt) begin
			idx  <= idx + 1'b1;					// Advance on the grant edge
			addr <= addr + hd_stride;
		end
		if (st_wready & st_wvalid) begin
			wdata_q <= st_wdata;
		end
		if (fin) begin
			done_dst <= hd_dst;
			done_no  <= hd_no;
		end
	end

endmodule

`default_nettype wire

//--- hdl/ldst_mem_arbiter.sv
// Shares one req/gnt memory port between the load and store channels.
// A request that is waiting keeps its port until granted.
// Round robin under contention, load first after reset.
`default_nettype none

module ldst_mem_arbiter (
	input  wire                  clock,
	input  wire                  rst_n,
	input  wire                  ld_req,
	input  wire ldst_pkg::addr_t ld_addr,
	input  wire                  st_req,
	input  wire ldst_pkg::addr_t st_addr,
	input  wire ldst_pkg::data_t st_wdata,
	input  wire                  mem_gnt,
	output logic                 ld_gnt,
	output logic                 st_gnt,
	output logic                 mem_req,
	output logic                 mem_we,
	output ldst_pkg::addr_t      mem_addr,
	output ldst_pkg::data_t      mem_wdata
);

	logic prefer_st;		// Store wins the next tie
	logic pend;				// Request out, grant not yet seen
	logic pend_st;			// Owner of that request
	logic sel_st;

	assign sel_st    = pend ? pend_st : (st_req & (~ld_req | prefer_st));
	assign mem_req   = ld_req | st_req;
	assign mem_we    = sel_st;
	assign mem_addr  = sel_st ? st_addr : ld_addr;
	assign mem_wdata = st_wdata;
	assign ld_gnt    = mem_gnt & ld_req & ~sel_st;
	assign st_gnt    = mem_gnt & sel_st;

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			prefer_st <= 1'b0;
			pend      <= 1'b0;
			pend_st   <= 1'b0;
		end else begin
			pend    <= mem_req & ~mem_gnt;	// Freeze choice while waiting
			pend_st <= sel_st;
			if (mem_req & mem_gnt) begin
				prefer_st <= ~sel_st;		// Loser gets the next tie
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/ldst_retire.sv
// Load write-back and completion report, both one cycle after their source.
// One done slot per channel; same-cycle dones go out oldest first.
`default_nettype none

module ldst_retire (
	input  wire                      clock,
	input  wire                      rst_n,
	input  wire ldst_pkg::issue_no_t newest_no,
	input  wire                      mem_rvalid,
	input  wire ldst_pkg::data_t     mem_rdata,
	input  wire ldst_pkg::idx_t      ld_idx,
	input  wire ldst_pkg::dst_t      ld_dst,
	input  wire                      ld_done,
	input  wire ldst_pkg::issue_no_t ld_done_no,
	input  wire                      st_done,
	input  wire ldst_pkg::issue_no_t st_done_no,
	output logic                     wb_valid,
	output ldst_pkg::dst_t           wb_dst,
	output ldst_pkg::idx_t           wb_idx,
	output ldst_pkg::data_t          wb_data,
	output logic                     done_valid,
	output ldst_pkg::issue_no_t      done_no,
	output logic                     done_is_store
);
	import ldst_pkg::*;

	logic      ld_pend;
	issue_no_t ld_pend_no;
	logic      st_pend;
	issue_no_t st_pend_no;
	logic      ld_c;			// Load done waiting to go out
	issue_no_t ld_c_no;
	logic      st_c;
	issue_no_t st_c_no;
	logic      pick_st;

	assign ld_c    = ld_pend | ld_done;
	assign ld_c_no = ld_pend ? ld_pend_no : ld_done_no;
	assign st_c    = st_pend | st_done;
	assign st_c_no = st_pend ? st_pend_no : st_done_no;
	assign pick_st = st_c & (~ld_c | is_older(st_c_no, ld_c_no, newest_no));

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			wb_valid   <= 1'b0;
			done_valid <= 1'b0;
			ld_pend    <= 1'b0;
			st_pend    <= 1'b0;
		end else begin
			wb_valid   <= mem_rvalid;
			done_valid <= ld_c | st_c;
			ld_pend    <= ld_c & pick_st;	// Younger one waits a cycle
			st_pend    <= st_c & ~pick_st;
		end
	end

	always_ff @(posedge clock) begin
		wb_dst        <= ld_dst;
		wb_idx        <= ld_idx;
		wb_data       <= mem_rdata;
		done_no       <= pick_st ? st_c_no : ld_c_no;
		done_is_store <= pick_st;
		ld_pend_no    <= ld_c_no;
		st_pend_no    <= st_c_no;
	end

endmodule

`default_nettype wire

//--- hdl/ldst_subsystem.sv
// Load/store block top: decoder, load and store channels, port arbiter, retire.
// Memory reads must return exactly one cycle after their grant.
`default_nettype none

module ldst_subsystem #(
	parameter int DEPTH_CMD = 4
)(
	input  wire                      clock,
	input  wire                      rst_n,
	input  wire                      req,
	input  wire ldst_pkg::op_type_t  op_type,
	input  wire                      op_class,
	input  wire ldst_pkg::dst_t      dst,
	input  wire ldst_pkg::issue_no_t issue_no,
	input  wire ldst_pkg::len_t      src_len,
	input  wire ldst_pkg::addr_t     src_stride,
	input  wire ldst_pkg::addr_t     src_base,
	output logic                     issue_stall,
	output logic                     mem_req,
	output logic                     mem_we,
	output ldst_pkg::addr_t          mem_addr,
	output ldst_pkg::data_t          mem_wdata,
	input  wire                      mem_gnt,
	input  wire                      mem_rvalid,
	input  wire ldst_pkg::data_t     mem_rdata,
	input  wire ldst_pkg::data_t     st_wdata,
	input  wire                      st_wvalid,
	output logic                     st_wready,
	output logic                     wb_valid,
	output ldst_pkg::dst_t           wb_dst,
	output ldst_pkg::idx_t           wb_idx,
	output ldst_pkg::data_t          wb_data,
	output logic                     done_valid,
	output ldst_pkg::issue_no_t      done_no,
	output logic                     done_is_store
);
	import ldst_pkg::*;

	logic      ld_full;
	logic      st_full;
	logic      ld_push;
	logic      st_push;
	len_t      cmd_len;
	addr_t     cmd_stride;
	addr_t     cmd_base;
	dst_t      cmd_dst;
	issue_no_t cmd_no;
	issue_no_t newest_no;
	logic      ld_req;
	addr_t     ld_addr;
	logic      ld_gnt;
	logic      st_req;
	addr_t     st_addr;
	data_t     st_mem_wdata;
	logic      st_gnt;
	idx_t      ld_idx;
	dst_t      ld_dst;
	logic      ld_done;
	issue_no_t ld_done_no;
	logic      st_done;
	issue_no_t st_done_no;

	ldst_cmd_decode cmd_decode (
		.clock(clock), .rst_n(rst_n), .req(req), .op_type(op_type), .op_class(op_class),
		.dst(dst), .issue_no(issue_no), .src_len(src_len), .src_stride(src_stride),
		.src_base(src_base), .ld_full(ld_full), .st_full(st_full),
		.issue_stall(issue_stall), .ld_push(ld_push), .st_push(st_push),
		.cmd_len(cmd_len), .cmd_stride(cmd_stride), .cmd_base(cmd_base),
		.cmd_dst(cmd_dst), .cmd_no(cmd_no), .newest_no(newest_no)
	);

	// Load copy has no store stream
	ldst_channel #(.DEPTH_CMD(DEPTH_CMD), .IS_STORE(1'b0)) ld_chan (
		.clock(clock), .rst_n(rst_n), .push(ld_push), .cmd_len(cmd_len),
		.cmd_stride(cmd_stride), .cmd_base(cmd_base), .cmd_dst(cmd_dst), .cmd_no(cmd_no),
		.gnt(ld_gnt), .rvalid(mem_rvalid), .st_wdata('0), .st_wvalid(1'b0),
		.full(ld_full), .mem_req(ld_req), .mem_addr(ld_addr), .mem_wdata(),
		.st_wready(), .cur_idx(ld_idx), .cur_dst(ld_dst), .done(ld_done),
		.done_dst(), .done_no(ld_done_no)
	);

	ldst_channel #(.DEPTH_CMD(DEPTH_CMD), .IS_STORE(1'b1)) st_chan (
		.clock(clock), .rst_n(rst_n), .push(st_push), .cmd_len(cmd_len),
		.cmd_stride(cmd_stride), .cmd_base(cmd_base), .cmd_dst(cmd_dst), .cmd_no(cmd_no),
		.gnt(st_gnt), .rvalid(1'b0), .st_wdata(st_wdata), .st_wvalid(st_wvalid),
		.full(st_full), .mem_req(st_req), .mem_addr(st_addr), .mem_wdata(st_mem_wdata),
		.st_wready(st_wready), .cur_idx(), .cur_dst(), .done(st_done),
		.done_dst(), .done_no(st_done_no)
	);

	ldst_mem_arbiter mem_arbiter (
		.clock(clock), .rst_n(rst_n), .ld_req(ld_req), .ld_addr(ld_addr),
		.st_req(st_req), .st_addr(st_addr), .st_wdata(st_mem_wdata), .mem_gnt(mem_gnt),
		.ld_gnt(ld_gnt), .st_gnt(st_gnt), .mem_req(mem_req), .mem_we(mem_we),
		.mem_addr(mem_addr), .mem_wdata(mem_wdata)
	);

	ldst_retire retire (
		.clock(clock), .rst_n(rst_n), .newest_no(newest_no), .mem_rvalid(mem_rvalid),
		.mem_rdata(mem_rdata), .ld_idx(ld_idx), .ld_dst(ld_dst), .ld_done(ld_done),
		.ld_done_no(ld_done_no), .st_done(st_done), .st_done_no(st_done_no),
		.wb_valid(wb_valid), .wb_dst(wb_dst), .wb_idx(wb_idx), .wb_data(wb_data),
		.done_valid(done_valid), .done_no(done_no), .done_is_store(done_is_store)
	);

endmodule

`default_nettype wire

//--- dv/ldst_mem_model.sv
// Testbench memory for the req/gnt port. Grant waits the delay given at request time.
// Reads return the address XOR 32'h5a5a_0000 one cycle after the grant.
// Writes change no contents and are only logged.
`default_nettype none

module ldst_mem_model (
	input  wire                  clock,
	input  wire                  rst_n,
	input  wire [1:0]            gnt_delay,
	input  wire                  mem_req,
	input  wire                  mem_we,
	input  wire ldst_pkg::addr_t mem_addr,
	input  wire ldst_pkg::data_t mem_wdata,
	output logic                 mem_gnt,
	output logic                 mem_rvalid,
	output ldst_pkg::data_t      mem_rdata
);
	import ldst_pkg::*;

	logic       armed;			// Request seen, delay running
	logic [1:0] wait_cnt;
	addr_t      wr_addr_log [$];
	data_t      wr_data_log [$];

	assign mem_gnt = mem_req & (armed ? (wait_cnt == 2'd0) : (gnt_delay == 2'd0));

	always @(posedge clock) begin
		if (!rst_n) begin
			armed      <= 1'b0;
			wait_cnt   <= 2'd0;
			mem_rvalid <= 1'b0;
		end else begin
			mem_rvalid <= mem_gnt & ~mem_we;			// Fixed read latency
			mem_rdata  <= mem_addr ^ 32'h5a5a_0000;
			if (mem_gnt) begin
				armed <= 1'b0;
			end else if (mem_req & ~armed) begin
				armed    <= 1'b1;
				wait_cnt <= gnt_delay - 2'd1;
			end else if (armed) begin
				wait_cnt <= wait_cnt - 2'd1;
			end
			if (mem_gnt & mem_we) begin
				wr_addr_log.push_back(mem_addr);
				wr_data_log.push_back(mem_wdata);
			end
		end
	end

endmodule

`default_nettype wire

//--- dv/ldst_tb.sv
// Testbench for the load/store block with a random-delay memory and a store data stream.
// Taps the two channel done pulses inside the DUT to count queue occupancy and
// to know which dones were waiting together in retire.
`default_nettype none

module ldst_tb;
	import ldst_pkg::*;

	localparam int    DEPTH_CMD = 4;
	localparam int    N_CMDS    = 60;
	localparam int    MAX_LEN   = 6;
	localparam int    MAX_DELAY = 8;		// Grant delay plus contention per element
	localparam int    TIMEOUT   = N_CMDS * (MAX_LEN * MAX_DELAY + 20);
	localparam data_t RD_KEY    = 32'h5a5a_0000;

	typedef struct {
		addr_t     base;
		addr_t     stride;
		len_t      len;
		dst_t      dst;
		issue_no_t no;
		int        seq;		// Issue order, older is smaller
	} cmd_t;

	typedef struct {
		dst_t  dst;
		idx_t  idx;
		data_t data;
	} wb_t;

	typedef struct {
		addr_t addr;
		data_t data;
	} wr_t;

	logic clock;
	logic rst_n;
	logic req;
	op_type_t op_type;
	logic op_class;
	dst_t dst;
	issue_no_t issue_no;
	len_t src_len;
	addr_t src_stride;
	addr_t src_base;
	logic issue_stall;
	logic mem_req;
	logic mem_we;
	addr_t mem_addr;
	data_t mem_wdata;
	logic mem_gnt;
	logic mem_rvalid;
	data_t mem_rdata;
	data_t st_wdata;
	logic st_wvalid;
	logic st_wready;
	logic wb_valid;
	dst_t wb_dst;
	idx_t wb_idx;
	data_t wb_data;
	logic done_valid;
	issue_no_t done_no;
	logic done_is_store;
	logic [1:0] gnt_delay;
	logic ld_done_tap;
	logic st_done_tap;

	logic [31:0] rng;
	logic run;
	logic cmd_taken;
	logic st_taken;
	int sent;
	int seq;
	int wr_seen;				// Memory log entries already compared
	int ld_acc;					// Accepted per direction
	int st_acc;
	int ld_fin;					// Channel dones seen
	int st_fin;
	int ld_rep;					// Dones reported by retire
	int st_rep;
	int ld_i;					// Element index of the walked command
	int st_i;
	cmd_t ld_walk[$];
	cmd_t st_walk[$];
	cmd_t ld_pend[$];
	cmd_t st_pend[$];
	data_t exp_words[$];
	wb_t exp_wb[$];
	wr_t exp_wr[$];

	ldst_subsystem #(.DEPTH_CMD(DEPTH_CMD)) ldst_subsystem_inst (
		.clock(clock), .rst_n(rst_n), .req(req), .op_type(op_type), .op_class(op_class),
		.dst(dst), .issue_no(issue_no), .src_len(src_len), .src_stride(src_stride),
		.src_base(src_base), .issue_stall(issue_stall), .mem_req(mem_req), .mem_we(mem_we),
		.mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_gnt(mem_gnt),
		.mem_rvalid(mem_rvalid), .mem_rdata(mem_rdata), .st_wdata(st_wdata),
		.st_wvalid(st_wvalid), .st_wready(st_wready), .wb_valid(wb_valid), .wb_dst(wb_dst),
		.wb_idx(wb_idx), .wb_data(wb_data), .done_valid(done_valid), .done_no(done_no),
		.done_is_store(done_is_store)
	);

	ldst_mem_model mem_model (
		.clock(clock), .rst_n(rst_n), .gnt_delay(gnt_delay), .mem_req(mem_req),
		.mem_we(mem_we), .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_gnt(mem_gnt),
		.mem_rvalid(mem_rvalid), .mem_rdata(mem_rdata)
	);

	assign ld_done_tap = ldst_subsystem_inst.ld_done;
	assign st_done_tap = ldst_subsystem_inst.st_done;

	////////////////////////////////////////////////////////////////////////////
	// Failure reporting and random numbers
	////////////////////////////////////////////////////////////////////////////

	task automatic abort_run();
		$display("test failed");
		$fatal(1);
	endtask

	task automatic report_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		$display("[ERROR] %0t: %s expected %h, got %h", $time, name, exp, act);
		abort_run();
	endtask

	task automatic report_text(input string msg);
		$display("[ERROR] %0t: %s", $time, msg);
		abort_run();
	endtask

	function automatic logic [31:0] next_rand();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Stimulus, all driven on the falling edge
	////////////////////////////////////////////////////////////////////////////

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	task automatic issue_command();
		logic [31:0] rnd;
		rnd        = next_rand();
		op_type    = (rnd[1:0] != 2'b00) ? OP_MEM : ((rnd[3:2] == 2'b11) ? 2'b00 : rnd[3:2]);
		op_class   = rnd[4];
		dst        = rnd[9:5];
		src_len    = len_t'(rnd[12:10] % 7);		// 0 to 6
		src_stride = addr_t'(rnd[15:13]);
		src_base   = next_rand();
		issue_no   = issue_no + 1'b1;
		req        = 1'b1;
	endtask

	always @(negedge clock) begin : drive
		logic [31:0] rnd;
		if (run) begin
			rnd       = next_rand();
			gnt_delay = rnd[1:0];
			if (st_taken || !st_wvalid) begin		// Hold a word until taken
				st_wvalid = (rnd[3:2] != 2'b00);
				st_wdata  = next_rand();
			end
			if (cmd_taken || !req) begin
				if (sent == N_CMDS || rnd[7:5] == 3'd0) begin
					req = 1'b0;					// Gap between bursts
				end else begin
					issue_command();
				end
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Reference model and checks
	////////////////////////////////////////////////////////////////////////////

	task automatic accept_command();
		cmd_t c;
		sent++;
		if (op_type == OP_MEM) begin
			seq++;
			c.base   = src_base;
			c.stride = src_stride;
			c.len    = src_len;
			c.dst    = dst;
			c.no     = issue_no;
			c.seq    = seq;
			if (op_class) begin
				st_acc++;
				st_pend.push_back(c);
				if (c.len != 0) st_walk.push_back(c);
			end else begin
				ld_acc++;
				ld_pend.push_back(c);
				if (c.len != 0) ld_walk.push_back(c);
			end
		end
	endtask

	task automatic check_grant();
		cmd_t  c;
		addr_t exp_addr;
		wb_t   w;
		wr_t   wr;
		if (mem_we) begin
			if (st_walk.size() == 0 || exp_words.size() == 0) begin
				report_text("store write with no store element pending");
			end else begin
				c       = st_walk[0];
				wr.addr = c.base + addr_t'(st_i) * c.stride;
				wr.data = exp_words.pop_front();
				exp_wr.push_back(wr);				// Matched against the memory's log
				st_i++;
				if (st_i == int'(c.len)) begin
					st_i = 0;
					void'(st_walk.pop_front());
				end
			end
		end else begin
			if (ld_walk.size() == 0) begin
				report_text("memory read with no load element pending");
			end else begin
				c        = ld_walk[0];
				exp_addr = c.base + addr_t'(ld_i) * c.stride;
				assert (mem_addr == exp_addr) else report_value("mem_addr", exp_addr, mem_addr);
				w.dst  = c.dst;
				w.idx  = idx_t'(ld_i);
				w.data = exp_addr ^ RD_KEY;
				exp_wb.push_back(w);
				ld_i++;
				if (ld_i == int'(c.len)) begin
					ld_i = 0;
					void'(ld_walk.pop_front());
				end
			end
		end
	endtask

	task automatic check_writeback();
		wb_t w;
		if (exp_wb.size() == 0) begin
			report_text("write-back with no load element outstanding");
		end else begin
			w = exp_wb.pop_front();
			assert (wb_dst == w.dst) else report_value("wb_dst", w.dst, wb_dst);
			assert (wb_idx == w.idx) else report_value("wb_idx", w.idx, wb_idx);
			assert (wb_data == w.data) else report_value("wb_data", w.data, wb_data);
		end
	endtask

	// Retire had the other direction waiting too when its channel done
	// was seen but not yet reported, so this one must be the older
	task automatic check_done();
		cmd_t c;
		int   other_ready;
		if (done_is_store ? (st_pend.size() == 0) : (ld_pend.size() == 0)) begin
			report_text("done reported with no command outstanding in that direction");
		end else begin
			c           = done_is_store ? st_pend[0] : ld_pend[0];
			other_ready = done_is_store ? (ld_fin - ld_rep) : (st_fin - st_rep);
			assert (done_no == c.no) else report_value("done_no", c.no, done_no);
			if (other_ready > 0) begin
				assert ((done_is_store ? ld_pend[0].seq : st_pend[0].seq) > c.seq)
					else report_text("younger command reported done before an older one");
			end
			if (done_is_store) begin
				void'(st_pend.pop_front());
				st_rep++;
			end else begin
				void'(ld_pend.pop_front());
				ld_rep++;
			end
		end
	endtask

	always @(posedge clock) begin : monitor
		int   ld_occ;
		int   st_occ;
		logic exp_stall;
		if (rst_n) begin
			ld_occ    = ld_acc - ld_fin - int'(ld_done_tap);		// Entries incl. push in flight
			st_occ    = st_acc - st_fin - int'(st_done_tap);
			exp_stall = req && (op_type == OP_MEM) && ((op_class ? st_occ : ld_occ) == DEPTH_CMD);
			assert (issue_stall == exp_stall)
				else report_value("issue_stall", exp_stall, issue_stall);
			cmd_taken = req && !issue_stall;
			if (cmd_taken) accept_command();
			if (mem_gnt) check_grant();
			if (wb_valid) check_writeback();
			if (done_valid) check_done();
			ld_fin += int'(ld_done_tap);
			st_fin += int'(st_done_tap);
			st_taken = st_wvalid && st_wready;
			if (st_taken) exp_words.push_back(st_wdata);
		end
	end

	// Store writes as the memory logged them on their grant edge, in order
	always @(negedge clock) begin : write_check
		wr_t w;
		while (wr_seen < mem_model.wr_addr_log.size()) begin
			if (exp_wr.size() == 0) begin
				report_text("memory logged a write that no store element expected");
			end else begin
				w = exp_wr.pop_front();
				assert (mem_model.wr_addr_log[wr_seen] == w.addr)
					else report_value("mem_addr", w.addr, mem_model.wr_addr_log[wr_seen]);
				assert (mem_model.wr_data_log[wr_seen] == w.data)
					else report_value("mem_wdata", w.data, mem_model.wr_data_log[wr_seen]);
			end
			wr_seen++;
		end
	end

	assert property (@(posedge clock) !rst_n |=>
			!issue_stall && !mem_req && !st_wready && !wb_valid && !done_valid)
		else report_text("DUT outputs active during or right after reset");

	assert property (@(posedge clock) disable iff (!rst_n)
			mem_req && !mem_gnt |=> mem_req && $stable(mem_addr) && $stable(mem_we))
		else report_text("memory request dropped or changed before its grant");

	////////////////////////////////////////////////////////////////////////////
	// Run control
	////////////////////////////////////////////////////////////////////////////

	initial begin : watchdog
		repeat (TIMEOUT) @(posedge clock);
		report_text("timeout with commands still outstanding");
	end

	initial begin
		rst_n      = 1'b0;
		req        = 1'b0;
		op_type    = 2'b00;
		op_class   = 1'b0;
		dst        = '0;
		issue_no   = '0;
		src_len    = '0;
		src_stride = '0;
		src_base   = '0;
		st_wdata   = '0;
		st_wvalid  = 1'b0;
		gnt_delay  = 2'd0;
		rng        = 32'hd2d1_29e7;
		run        = 1'b0;
		cmd_taken  = 1'b0;
		st_taken   = 1'b0;
		repeat (2) @(posedge clock);
		@(negedge clock);
		rst_n = 1'b1;
		@(posedge clock);
		run = 1'b1;
		while (sent < N_CMDS || ld_pend.size() != 0 || st_pend.size() != 0
				|| exp_wb.size() != 0) begin
			@(negedge clock);
		end
		repeat (4) @(negedge clock);		// Catch any stray traffic
		if (exp_words.size() == 0 && ld_walk.size() == 0 && st_walk.size() == 0) begin
			$display("test passed");
			$finish;
		end else begin
			report_text("store writes missing or element traffic left over at the end");
		end
	end

endmodule

`default_nettype wire

//--- filelist.f
hdl/ldst_pkg.sv
hdl/ldst_cmd_decode.sv
hdl/ldst_channel.sv
hdl/ldst_mem_arbiter.sv
hdl/ldst_retire.sv
hdl/ldst_subsystem.sv
dv/ldst_mem_model.sv
dv/ldst_tb.sv

//--- Bender.yml
package:
  name: ldst_subsystem

sources:
  - hdl/ldst_pkg.sv
  - hdl/ldst_cmd_decode.sv
  - hdl/ldst_channel.sv
  - hdl/ldst_mem_arbiter.sv
  - hdl/ldst_retire.sv
  - hdl/ldst_subsystem.sv
  - target: simulation
    files:
      - dv/ldst_mem_model.sv
      - dv/ldst_tb.sv
